/* hw/hpu_task_pkg.sv */
/*
 * Task-side types for the handler processing unit driver.
 * Holds the core bus request/response, the scheduler task, the feedback
 * descriptor, the sequencer states and the task window word map.
 */
package hpu_task_pkg;

    localparam int MSGID_W = 10;

    // window select from address bits 8:7
    localparam logic [1:0] TASK_WIN = 2'd0;
    localparam logic [1:0] CMD_WIN  = 2'd1;

    localparam int TASK_INFO_WORDS = 14;
    // reading this word ends the handler
    localparam int TERM_WORD       = 14;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
        logic        we;
        logic [31:0] wdata;
    } periph_req_t;

    typedef struct packed {
        logic        gnt;
        logic        r_valid;
        logic [31:0] rdata;
    } periph_rsp_t;

    typedef struct packed {
        logic [31:0]        handler_fun;
        logic [31:0]        handler_fun_size;
        logic [31:0]        handler_mem_addr;
        logic [31:0]        handler_mem_size;
        logic [31:0]        pkt_ptr;
        logic [31:0]        pkt_addr;
        logic [31:0]        pkt_size;
        logic [MSGID_W-1:0] msgid;
        logic [63:0]        host_mem_addr;
        logic [31:0]        host_mem_size;
        logic               trigger_feedback;
    } handler_task_t;

    typedef struct packed {
        logic [31:0]        pkt_ptr;
        logic [31:0]        pkt_addr;
        logic [MSGID_W-1:0] msgid;
        logic [31:0]        pkt_size;
        logic               trigger_feedback;
    } feedback_t;

    typedef enum logic [1:0] {Init, Idle, Running, SendingFeedback} task_state_e;

endpackage

/* hw/hpu_cmd_pkg.sv */
/*
 * Command-side types for the handler processing unit driver.
 * Holds the opcodes, the command and completion descriptors, the frontend
 * states and the command window word map.
 */
package hpu_cmd_pkg;

    localparam int NUM_CMDS  = 4;
    localparam int CMD_ID_W  = 2;
    localparam int CMD_WORDS = 7;

    // command window word indices
    localparam int ISSUE_WORD = 0;
    localparam int WAIT_WORD  = 1;
    localparam int TEST_WORD  = 2;
    localparam int TYPE_WORD  = 3;
    localparam int DESCR_BASE = 4;

    // written in bits 2:1 of the type word
    typedef enum logic [1:0] {
        HostMemCpy = 2'd0,
        NicSend    = 2'd1,
        HostDirect = 2'd2
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e                    op;
        logic                       gen_event;
        logic [CMD_ID_W-1:0]        id;
        logic [CMD_WORDS-1:0][31:0] words;
    } hpu_cmd_t;

    typedef struct packed {
        logic [CMD_ID_W-1:0] id;
    } cmd_resp_t;

    typedef enum logic [1:0] {Ready, WaitingSlot, WaitingId, Waiting} cmd_state_e;

endpackage

/* hw/task_sequencer.sv */
/*
 * Handler lifecycle of the core. Takes a task from the scheduler, keeps it
 * as the current task while the handler runs, and moves its feedback into
 * a one-entry slot that is offered once no command is in flight.
 */
`timescale 1ns/1ps

module task_sequencer (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        task_valid_i,
    output logic                        task_ready_o,
    input  hpu_task_pkg::handler_task_t task_i,
    output logic                        feedback_valid_o,
    input  logic                        feedback_ready_i,
    output hpu_task_pkg::feedback_t     feedback_o,
    output logic                        hpu_active_o,
    input  logic                        win_req_i,
    input  logic                        term_i,
    input  logic                        idle_cmds_i,
    output hpu_task_pkg::handler_task_t cur_task_o,
    output logic                        running_o
);
    import hpu_task_pkg::*;

    task_state_e   state_q, state_d;
    handler_task_t cur_task_q;
    feedback_t     fb, slot_q;
    logic          slot_full_q, slot_push, slot_pop, accept;

    assign task_ready_o     = (state_q == Idle);
    assign hpu_active_o     = (state_q != Init);
    assign running_o        = (state_q == Running);
    assign cur_task_o       = cur_task_q;
    assign accept           = task_valid_i && task_ready_o;
    // held back while any command of this handler is outstanding
    assign feedback_valid_o = slot_full_q && idle_cmds_i;
    assign feedback_o       = slot_q;
    assign slot_pop         = feedback_valid_o && feedback_ready_i;

    assign fb = '{pkt_ptr:          cur_task_q.pkt_ptr,
                  pkt_addr:         cur_task_q.pkt_addr,
                  msgid:            cur_task_q.msgid,
                  pkt_size:         cur_task_q.pkt_size,
                  trigger_feedback: cur_task_q.trigger_feedback};

    always_comb begin
        state_d   = state_q;
        slot_push = 1'b0;
        case (state_q)
            Init: begin
                // first access from the core means the runtime is up
                if (win_req_i) state_d = Idle;
            end
            Idle: begin
                if (accept) begin
                    state_d = (task_i.handler_fun == '0) ? SendingFeedback : Running;
                end
            end
            Running: begin
                if (term_i) begin
                    slot_push = !slot_full_q || slot_pop;
                    state_d   = slot_push ? Idle : SendingFeedback;
                end
            end
            SendingFeedback: begin
                slot_push = !slot_full_q || slot_pop;
                if (slot_push) state_d = Idle;
            end
            default: state_d = Init;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= Init;
            slot_full_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            slot_full_q <= slot_push || (slot_full_q && !slot_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) cur_task_q <= task_i;
        if (slot_push) slot_q <= fb;
    end

endmodule

/* hw/task_info_regs.sv */
/*
 * Read window over the current task for the core. Grants only while a
 * handler runs, returns the selected word one cycle later and flags the
 * read of the termination word to the sequencer.
 */
`timescale 1ns/1ps

module task_info_regs (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  hpu_task_pkg::periph_req_t   req_i,
    input  logic                        running_i,
    input  hpu_task_pkg::handler_task_t cur_task_i,
    output hpu_task_pkg::periph_rsp_t   rsp_o,
    output logic                        term_o
);
    import hpu_task_pkg::*;

    logic [TASK_INFO_WORDS-1:0][31:0] info;
    logic [4:0]                       word;
    logic                             gnt, r_valid_q;
    logic [31:0]                      rdata_d, rdata_q;

    assign word   = req_i.addr[6:2];
    assign gnt    = req_i.req && running_i;
    assign term_o = gnt && !req_i.we && (word == TERM_WORD);

    // word map seen by the runtime
    assign info[0]  = cur_task_i.handler_fun;
    assign info[1]  = cur_task_i.handler_fun_size;
    assign info[2]  = cur_task_i.handler_mem_addr;
    assign info[3]  = cur_task_i.handler_mem_size;
    assign info[4]  = cur_task_i.pkt_ptr;
    assign info[5]  = cur_task_i.pkt_size;
    assign info[6]  = cur_task_i.host_mem_addr[63:32];
    assign info[7]  = cur_task_i.host_mem_addr[31:0];
    assign info[8]  = cur_task_i.host_mem_size;
    assign info[9]  = cur_task_i.pkt_addr;
    assign info[10] = 32'(cur_task_i.msgid);
    assign info[11] = 32'(cur_task_i.trigger_feedback);
    assign info[12] = '0;
    assign info[13] = '0;

    // writes and the termination word read back as zero
    always_comb begin
        rdata_d = '0;
        if (!req_i.we && word < TASK_INFO_WORDS) begin
            rdata_d = info[word[3:0]];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            r_valid_q <= 1'b0;
        end else begin
            r_valid_q <= gnt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (gnt) rdata_q <= rdata_d;
    end

    assign rsp_o = '{gnt: gnt, r_valid: r_valid_q, rdata: rdata_q};

endmodule

/* hw/cmd_id_pool.sv */
/*
 * Pool of command IDs for one core. Keeps a bitmap of IDs in flight,
 * offers the lowest clear one for the next issue and frees an ID when the
 * command engine reports its completion.
 */
`timescale 1ns/1ps

module cmd_id_pool (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             alloc_i,
    input  logic                             resp_valid_i,
    input  hpu_cmd_pkg::cmd_resp_t           resp_i,
    output logic [hpu_cmd_pkg::CMD_ID_W-1:0] free_id_o,
    output logic                             none_free_o,
    output logic [hpu_cmd_pkg::NUM_CMDS-1:0] busy_o,
    output logic                             all_idle_o
);
    import hpu_cmd_pkg::*;

    logic [NUM_CMDS-1:0] busy_q, busy_d;

    assign busy_o      = busy_q;
    assign none_free_o = &busy_q;
    assign all_idle_o  = (busy_q == '0);

    // scan downwards so the lowest clear bit wins
    always_comb begin
        free_id_o = '0;
        for (int i = NUM_CMDS - 1; i >= 0; i--) begin
            if (!busy_q[i]) free_id_o = CMD_ID_W'(i);
        end
    end

    // an allocated ID is free, a completed one busy, so they never collide
    always_comb begin
        busy_d = busy_q;
        if (alloc_i) busy_d[free_id_o] = 1'b1;
        if (resp_valid_i) busy_d[resp_i.id] = 1'b0;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

endmodule

/* hw/cmd_frontend.sv */
/*
 * Command window of the core. Collects opcode, event flag and descriptor
 * words, hands out an ID on issue and parks the command in a single-entry
 * output slot. Wait and test let the core follow an ID to its completion.
 */
`timescale 1ns/1ps

module cmd_frontend (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  hpu_task_pkg::periph_req_t        req_i,
    output hpu_task_pkg::periph_rsp_t        rsp_o,
    input  logic [hpu_cmd_pkg::CMD_ID_W-1:0] free_id_i,
    input  logic                             none_free_i,
    input  logic [hpu_cmd_pkg::NUM_CMDS-1:0] busy_i,
    output logic                             alloc_o,
    input  logic                             resp_valid_i,
    input  hpu_cmd_pkg::cmd_resp_t           resp_i,
    output logic                             cmd_valid_o,
    input  logic                             cmd_ready_i,
    output hpu_cmd_pkg::hpu_cmd_t            cmd_o
);
    import hpu_task_pkg::*;
    import hpu_cmd_pkg::*;

    cmd_state_e                 state_q, state_d;
    logic [4:0]                 word;
    logic [2:0]                 descr_idx;
    logic [CMD_ID_W-1:0]        req_id, wt_id_q;
    logic                       issue_req, wait_req, wt_wr, test_rd, type_wr, descr_wr;
    logic                       issue_ok, wait_done, gnt, r_valid_q;
    logic [31:0]                rdata_d, rdata_q;
    cmd_op_e                    op_q;
    logic                       event_q;
    logic [CMD_WORDS-1:0][31:0] words_q;
    logic                       slot_full_q;
    hpu_cmd_t                   slot_q;

    assign word      = req_i.addr[6:2];
    assign descr_idx = 3'(word - 5'(DESCR_BASE));
    assign req_id    = req_i.wdata[CMD_ID_W-1:0];

    assign issue_req = req_i.req && !req_i.we && (word == ISSUE_WORD);
    assign wait_req  = req_i.req && req_i.we && (word == WAIT_WORD);
    assign wt_wr     = req_i.req && req_i.we && (word == WAIT_WORD || word == TEST_WORD);
    assign test_rd   = req_i.req && !req_i.we && (word == TEST_WORD);
    assign type_wr   = req_i.req && req_i.we && (word == TYPE_WORD);
    assign descr_wr  = req_i.req && req_i.we && word >= DESCR_BASE
                       && word < DESCR_BASE + CMD_WORDS;

    assign issue_ok  = !none_free_i && !slot_full_q;
    // a completion arriving this cycle counts as done
    assign wait_done = !busy_i[req_id] || (resp_valid_i && resp_i.id == req_id);

    // the core holds its request, so a stalled state just re-checks it
    always_comb begin
        state_d = state_q;
        gnt     = 1'b0;
        case (state_q)
            Ready: begin
                if (issue_req && !issue_ok) begin
                    state_d = none_free_i ? WaitingId : WaitingSlot;
                end else if (wait_req && !wait_done) begin
                    state_d = Waiting;
                end else begin
                    gnt = req_i.req;
                end
            end
            WaitingId, WaitingSlot: begin
                if (issue_ok) begin
                    gnt     = 1'b1;
                    state_d = Ready;
                end else begin
                    state_d = none_free_i ? WaitingId : WaitingSlot;
                end
            end
            Waiting: begin
                if (resp_valid_i && resp_i.id == wt_id_q) begin
                    gnt     = 1'b1;
                    state_d = Ready;
                end
            end
            default: state_d = Ready;
        endcase
    end

    assign alloc_o = gnt && issue_req;

    // issue returns the new ID, a test read returns 1 for a free ID
    always_comb begin
        rdata_d = '0;
        if (issue_req) begin
            rdata_d = 32'(free_id_i);
        end else if (test_rd) begin
            rdata_d = {31'b0, !busy_i[wt_id_q]};
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= Ready;
            r_valid_q   <= 1'b0;
            wt_id_q     <= '0;
            slot_full_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            r_valid_q <= gnt;
            if (state_q == Ready && wt_wr) wt_id_q <= req_id;
            if (alloc_o) begin
                slot_full_q <= 1'b1;
            end else if (cmd_valid_o && cmd_ready_i) begin
                slot_full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (gnt) rdata_q <= rdata_d;
        if (gnt && type_wr) begin
            op_q    <= cmd_op_e'(req_i.wdata[2:1]);
            event_q <= req_i.wdata[0];
        end
        if (gnt && descr_wr) words_q[descr_idx] <= req_i.wdata;
        if (alloc_o) begin
            slot_q <= '{op: op_q, gen_event: event_q, id: free_id_i, words: words_q};
        end
    end

    assign cmd_valid_o = slot_full_q;
    assign cmd_o       = slot_q;
    assign rsp_o       = '{gnt: gnt, r_valid: r_valid_q, rdata: rdata_q};

endmodule

/* hw/hpu_driver.sv */
/*
 * Driver beside one packet-handler core. Splits the core bus between the
 * task window and the command window by address bits 8:7, and ties the
 * task sequencer and the command frontend to their register blocks.
 */
`timescale 1ns/1ps

module hpu_driver (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        task_valid_i,
    output logic                        task_ready_o,
    input  hpu_task_pkg::handler_task_t task_i,
    output logic                        feedback_valid_o,
    input  logic                        feedback_ready_i,
    output hpu_task_pkg::feedback_t     feedback_o,
    output logic                        hpu_active_o,
    input  hpu_task_pkg::periph_req_t   bus_req_i,
    output hpu_task_pkg::periph_rsp_t   bus_rsp_o,
    output logic                        cmd_valid_o,
    input  logic                        cmd_ready_i,
    output hpu_cmd_pkg::hpu_cmd_t       cmd_o,
    input  logic                        cmd_resp_valid_i,
    input  hpu_cmd_pkg::cmd_resp_t      cmd_resp_i
);
    import hpu_task_pkg::*;
    import hpu_cmd_pkg::*;

    logic [1:0]          sel, sel_q;
    periph_req_t         task_req, cmd_req;
    periph_rsp_t         task_rsp, cmd_rsp;
    handler_task_t       cur_task;
    logic                running, term;
    logic [CMD_ID_W-1:0] free_id;
    logic                none_free, alloc, all_idle;
    logic [NUM_CMDS-1:0] busy;

    assign sel = bus_req_i.addr[8:7];

    always_comb begin
        task_req     = bus_req_i;
        cmd_req      = bus_req_i;
        task_req.req = bus_req_i.req && (sel == TASK_WIN);
        cmd_req.req  = bus_req_i.req && (sel == CMD_WIN);
    end

    // grant follows the live select, read data the one from last cycle
    always_comb begin
        bus_rsp_o = '0;
        case (sel)
            TASK_WIN: bus_rsp_o.gnt = task_rsp.gnt;
            CMD_WIN:  bus_rsp_o.gnt = cmd_rsp.gnt;
            default:  bus_rsp_o.gnt = 1'b0;
        endcase
        if (sel_q == TASK_WIN) begin
            bus_rsp_o.r_valid = task_rsp.r_valid;
            bus_rsp_o.rdata   = task_rsp.rdata;
        end else if (sel_q == CMD_WIN) begin
            bus_rsp_o.r_valid = cmd_rsp.r_valid;
            bus_rsp_o.rdata   = cmd_rsp.rdata;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q <= TASK_WIN;
        end else begin
            sel_q <= sel;
        end
    end

    task_sequencer u_task_sequencer (
        .clk_i, .rst_ni, .task_valid_i, .task_ready_o, .task_i,
        .feedback_valid_o, .feedback_ready_i, .feedback_o, .hpu_active_o,
        .win_req_i   (task_req.req),
        .term_i      (term),
        .idle_cmds_i (all_idle),
        .cur_task_o  (cur_task),
        .running_o   (running)
    );

    task_info_regs u_task_info_regs (
        .clk_i, .rst_ni,
        .req_i      (task_req),
        .running_i  (running),
        .cur_task_i (cur_task),
        .rsp_o      (task_rsp),
        .term_o     (term)
    );

    cmd_id_pool u_cmd_id_pool (
        .clk_i, .rst_ni,
        .alloc_i      (alloc),
        .resp_valid_i (cmd_resp_valid_i),
        .resp_i       (cmd_resp_i),
        .free_id_o    (free_id),
        .none_free_o  (none_free),
        .busy_o       (busy),
        .all_idle_o   (all_idle)
    );

    cmd_frontend u_cmd_frontend (
        .clk_i, .rst_ni,
        .req_i        (cmd_req),
        .rsp_o        (cmd_rsp),
        .free_id_i    (free_id),
        .none_free_i  (none_free),
        .busy_i       (busy),
        .alloc_o      (alloc),
        .resp_valid_i (cmd_resp_valid_i),
        .resp_i       (cmd_resp_i),
        .cmd_valid_o, .cmd_ready_i, .cmd_o
    );

endmodule

/* tb/hpu_checker.sv */
/*
 * Result side of the driver testbench. Records every feedback and command
 * handshake seen on the DUT ports, compares them and any sampled value
 * against what the test expects, and keeps the pass and fail counts.
 */
`timescale 1ns/1ps

module hpu_checker (
    input  logic                    clk_i,
    input  logic                    feedback_valid_i,
    input  logic                    feedback_ready_i,
    input  hpu_task_pkg::feedback_t feedback_i,
    input  logic                    cmd_valid_i,
    input  logic                    cmd_ready_i,
    input  hpu_cmd_pkg::hpu_cmd_t   cmd_i
);
    import hpu_task_pkg::*;
    import hpu_cmd_pkg::*;

    int        pass_count = 0;
    int        fail_count = 0;
    feedback_t fb_q[$];
    hpu_cmd_t  cmd_q[$];

    // transfers land here, the test pops them in order
    always @(posedge clk_i) begin
        if (feedback_valid_i && feedback_ready_i) fb_q.push_back(feedback_i);
        if (cmd_valid_i && cmd_ready_i) cmd_q.push_back(cmd_i);
    end

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got === exp) begin
            pass_count++;
            $display("[ok] t=%0t %s = %0h", $time, name, got);
        end else begin
            fail_count++;
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        fail_count++;
        $display("[error] t=%0t %s", $time, what);
    endtask

    task automatic expect_feedback(input feedback_t exp);
        int n;
        n = 0;
        while (fb_q.size() == 0 && n < 512) begin
            @(posedge clk_i);
            n++;
        end
        if (fb_q.size() == 0) begin
            report_problem("no feedback handshake seen on the feedback port");
        end else begin
            check_value("feedback_o", 256'(fb_q.pop_front()), 256'(exp));
        end
    endtask

    task automatic expect_cmd(input hpu_cmd_t exp);
        int n;
        n = 0;
        while (cmd_q.size() == 0 && n < 512) begin
            @(posedge clk_i);
            n++;
        end
        if (cmd_q.size() == 0) begin
            report_problem("no command handshake seen on the command port");
        end else begin
            check_value("cmd_o", 256'(cmd_q.pop_front()), 256'(exp));
        end
    endtask

    task automatic print_counts();
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
    endtask

endmodule

/* tb/tb_hpu_driver.sv */
/*
 * Testbench for the driver. Builds a table of bus accesses, task pushes,
 * completions and drains, applies it in order against the DUT and lets
 * the checker compare. Ready stalls come from a seeded random stream.
 */
`timescale 1ns/1ps

module tb_hpu_driver;
    import hpu_task_pkg::*;
    import hpu_cmd_pkg::*;

    localparam logic [3:0] OP_RST_CHK = 4'd0, OP_POKE = 4'd1, OP_PUSH = 4'd2;
    localparam logic [3:0] OP_RD = 4'd3, OP_WR = 4'd4, OP_RESP = 4'd5;
    localparam logic [3:0] OP_DRAIN_FB = 4'd6, OP_DRAIN_CMD = 4'd7, OP_FB_QUIET = 4'd8;
    localparam logic [3:0] OP_ISSUE_BLK = 4'd9, OP_WAIT_BLK = 4'd10;

    typedef struct packed {
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  idx;
        logic [31:0] exp;
    } entry_t;

    logic          clk_i, rst_ni;
    logic          task_valid_i, task_ready_o, feedback_valid_o, feedback_ready_i;
    logic          hpu_active_o, cmd_valid_o, cmd_ready_i, cmd_resp_valid_i;
    handler_task_t task_i;
    feedback_t     feedback_o;
    periph_req_t   bus_req_i;
    periph_rsp_t   bus_rsp_o;
    hpu_cmd_t      cmd_o;
    cmd_resp_t     cmd_resp_i;

    entry_t        table_q[$];
    handler_task_t tasks[2];
    logic [1:0]    exp_op;
    logic          exp_event;
    logic [CMD_WORDS-1:0][31:0] exp_words;

    hpu_driver u_dut (.*);

    hpu_checker u_chk (
        .clk_i, .feedback_valid_i(feedback_valid_o), .feedback_ready_i,
        .feedback_i(feedback_o), .cmd_valid_i(cmd_valid_o), .cmd_ready_i,
        .cmd_i(cmd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] task_addr(input int w);
        return 32'(w) << 2;
    endfunction

    function automatic logic [31:0] cmd_addr(input int w);
        return 32'h80 | (32'(w) << 2);
    endfunction

    function automatic handler_task_t make_task(input int i);
        handler_task_t t;
        t.handler_fun      = (i == 1) ? 32'h0 : 32'h1c00_0100;
        t.handler_fun_size = 32'h0000_0240 + 32'(i);
        t.handler_mem_addr = 32'h1000_8000 + 32'(i);
        t.handler_mem_size = 32'h0000_1000;
        t.pkt_ptr          = 32'h1000_2000 + 32'(i * 64);
        t.pkt_addr         = 32'h8000_4400 + 32'(i);
        t.pkt_size         = 32'd512 + 32'(i);
        t.msgid            = 10'(i * 7 + 3);
        t.host_mem_addr    = 64'hdead_0001_2345_6780 + 64'(i);
        t.host_mem_size    = 32'h0010_0000;
        t.trigger_feedback = (i == 0);
        return t;
    endfunction

    // word map of the task window as the runtime sees it
    function automatic logic [31:0] task_word(input handler_task_t t, input int w);
        case (w)
            0:  return t.handler_fun;
            1:  return t.handler_fun_size;
            2:  return t.handler_mem_addr;
            3:  return t.handler_mem_size;
            4:  return t.pkt_ptr;
            5:  return t.pkt_size;
            6:  return t.host_mem_addr[63:32];
            7:  return t.host_mem_addr[31:0];
            8:  return t.host_mem_size;
            9:  return t.pkt_addr;
            10: return {22'b0, t.msgid};
            11: return {31'b0, t.trigger_feedback};
            default: return 32'h0;
        endcase
    endfunction

    task automatic add(input logic [3:0] op, input logic [31:0] addr,
                       input logic [31:0] data, input logic [1:0] idx, input logic [31:0] exp);
        entry_t e;
        e = '{op: op, addr: addr, data: data, idx: idx, exp: exp};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        add(OP_RST_CHK, 0, 0, 0, 0);
        add(OP_POKE, 0, 0, 0, 32'd3);
        add(OP_PUSH, 0, 0, 0, 0);
        for (int w = 0; w < TASK_INFO_WORDS; w++) begin
            add(OP_RD, task_addr(w), 0, 0, task_word(tasks[0], w));
        end
        add(OP_WR, cmd_addr(TYPE_WORD), 32'h3, 0, 0);
        for (int w = 0; w < CMD_WORDS; w++) begin
            add(OP_WR, cmd_addr(DESCR_BASE + w), 32'hc0de_0000 + 32'(w), 0, 0);
        end
        for (int k = 0; k < NUM_CMDS; k++) begin
            add(OP_WR, cmd_addr(DESCR_BASE + 2), 32'h5a5a_0000 + 32'(k), 0, 0);
            add(OP_RD, cmd_addr(ISSUE_WORD), 0, 0, 32'(k));
            add(OP_DRAIN_CMD, 0, 0, 0, 32'(k));
        end
        add(OP_WR, cmd_addr(TEST_WORD), 32'd1, 0, 0);
        add(OP_RD, cmd_addr(TEST_WORD), 0, 0, 32'd0);
        add(OP_RD, task_addr(TERM_WORD), 0, 0, 32'd0);
        add(OP_FB_QUIET, 0, 0, 0, 0);
        add(OP_WR, cmd_addr(TYPE_WORD), 32'h4, 0, 0);
        add(OP_ISSUE_BLK, cmd_addr(ISSUE_WORD), 32'd2, 0, 32'd2);
        add(OP_DRAIN_CMD, 0, 0, 0, 32'd2);
        add(OP_RESP, 0, 32'd1, 0, 0);
        add(OP_WR, cmd_addr(TEST_WORD), 32'd1, 0, 0);
        add(OP_RD, cmd_addr(TEST_WORD), 0, 0, 32'd1);
        add(OP_WR, cmd_addr(WAIT_WORD), 32'd1, 0, 0);
        add(OP_WAIT_BLK, cmd_addr(WAIT_WORD), 32'd0, 0, 0);
        add(OP_RESP, 0, 32'd2, 0, 0);
        add(OP_FB_QUIET, 0, 0, 0, 0);
        add(OP_RESP, 0, 32'd3, 0, 0);
        add(OP_DRAIN_FB, 0, 0, 0, 0);
        // zero handler address skips the handler entirely
        add(OP_PUSH, 0, 0, 1, 0);
        add(OP_DRAIN_FB, 0, 0, 1, 0);
    endtask

    // holds the request until granted, then collects the response
    task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
                              input int min_wait, input logic [CMD_ID_W-1:0] resp_id,
                              output logic [31:0] rdata);
        int n;
        n = 0;
        rdata = '0;
        bus_req_i <= '{req: 1'b1, addr: addr, we: we, wdata: data};
        @(posedge clk_i);
        while (!bus_rsp_o.gnt && n < 256) begin
            if (n == min_wait && min_wait > 0) begin
                cmd_resp_valid_i <= 1'b1;
                cmd_resp_i       <= '{id: resp_id};
            end else begin
                cmd_resp_valid_i <= 1'b0;
            end
            @(posedge clk_i);
            n++;
        end
        bus_req_i.req    <= 1'b0;
        cmd_resp_valid_i <= 1'b0;
        if (!bus_rsp_o.gnt) begin
            u_chk.report_problem("bus request was never granted");
        end else begin
            if (min_wait > 0 && n <= min_wait) u_chk.report_problem("granted before its completion");
            @(posedge clk_i);
            if (!bus_rsp_o.r_valid) u_chk.report_problem("no read-valid after the grant");
            rdata = bus_rsp_o.rdata;
        end
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] rd;
        feedback_t   fb;
        hpu_cmd_t    c;
        int          n;
        case (e.op)
            OP_RST_CHK: u_chk.check_value("reset outputs", 256'({task_ready_o, feedback_valid_o,
                            cmd_valid_o, hpu_active_o, bus_rsp_o.gnt}), 256'(e.exp));
            OP_POKE: begin
                bus_req_i <= '{req: 1'b1, addr: e.addr, we: 1'b0, wdata: 32'h0};
                // the Init cycle sees the request but never grants it
                @(posedge clk_i);
                n = bus_rsp_o.gnt;
                @(posedge clk_i);
                n = n + bus_rsp_o.gnt;
                bus_req_i.req <= 1'b0;
                u_chk.check_value("bus_rsp_o.gnt", 256'(n), 256'(0));
                u_chk.check_value("hpu_active_o/task_ready_o",
                                  256'({hpu_active_o, task_ready_o}), 256'(e.exp));
            end
            OP_PUSH: begin
                task_valid_i <= 1'b1;
                task_i       <= tasks[e.idx];
                n = 0;
                @(posedge clk_i);
                while (!task_ready_o && n < 256) begin
                    @(posedge clk_i);
                    n++;
                end
                task_valid_i <= 1'b0;
                if (!task_ready_o) u_chk.report_problem("task was never accepted");
            end
            OP_RD: begin
                bus_access(1'b0, e.addr, 32'h0, 0, 2'd0, rd);
                u_chk.check_value("rdata", 256'(rd), 256'(e.exp));
            end
            OP_WR: begin
                if (e.addr == cmd_addr(TYPE_WORD)) begin
                    exp_op    = e.data[2:1];
                    exp_event = e.data[0];
                end else if (e.addr >= cmd_addr(DESCR_BASE)) begin
                    exp_words[(e.addr - cmd_addr(DESCR_BASE)) >> 2] = e.data;
                end
                bus_access(1'b1, e.addr, e.data, 0, 2'd0, rd);
            end
            OP_RESP: begin
                cmd_resp_valid_i <= 1'b1;
                cmd_resp_i       <= '{id: e.data[1:0]};
                @(posedge clk_i);
                cmd_resp_valid_i <= 1'b0;
                @(posedge clk_i);
            end
            OP_ISSUE_BLK, OP_WAIT_BLK: begin
                bus_access(e.op == OP_WAIT_BLK, e.addr, e.data, 8, e.data[1:0], rd);
                if (e.op == OP_ISSUE_BLK) u_chk.check_value("rdata", 256'(rd), 256'(e.exp));
            end
            OP_FB_QUIET: begin
                n = 0;
                for (int k = 0; k < 8; k++) begin
                    @(posedge clk_i);
                    if (feedback_valid_o) n++;
                end
                u_chk.check_value("feedback_valid_o", 256'(n), 256'(0));
            end
            OP_DRAIN_FB: begin
                fb.pkt_ptr          = tasks[e.idx].pkt_ptr;
                fb.pkt_addr         = tasks[e.idx].pkt_addr;
                fb.msgid            = tasks[e.idx].msgid;
                fb.pkt_size         = tasks[e.idx].pkt_size;
                fb.trigger_feedback = tasks[e.idx].trigger_feedback;
                u_chk.expect_feedback(fb);
            end
            default: begin
                c.op        = cmd_op_e'(exp_op);
                c.gen_event = exp_event;
                c.id        = e.exp[1:0];
                c.words     = exp_words;
                u_chk.expect_cmd(c);
            end
        endcase
    endtask

    // random back-pressure on both output ports
    initial begin
        void'($urandom(32'h9b55));
        forever begin
            @(posedge clk_i);
            if (rst_ni) begin
                feedback_ready_i <= ($urandom % 3) != 0;
                cmd_ready_i      <= ($urandom % 3) != 0;
            end
        end
    end

    initial begin
        rst_ni           = 1'b0;
        task_valid_i     = 1'b0;
        task_i           = '0;
        feedback_ready_i = 1'b0;
        cmd_ready_i      = 1'b0;
        bus_req_i        = '0;
        cmd_resp_valid_i = 1'b0;
        cmd_resp_i       = '0;
        exp_op           = '0;
        exp_event        = 1'b0;
        exp_words        = '0;
        tasks[0]         = make_task(0);
        tasks[1]         = make_task(1);
        build_table();
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        for (int i = 0; i < table_q.size(); i++) begin
            run_entry(table_q[i]);
        end
        u_chk.print_counts();
        if (u_chk.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // budget of 64 cycles per table entry
    initial begin
        wait (table_q.size() > 0);
        repeat (table_q.size() * 64 + 16) @(posedge clk_i);
        $display("watchdog expired before the table finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* filelist.f */
hw/hpu_task_pkg.sv
hw/hpu_cmd_pkg.sv
hw/task_sequencer.sv
hw/task_info_regs.sv
hw/cmd_id_pool.sv
hw/cmd_frontend.sv
hw/hpu_driver.sv
tb/hpu_checker.sv
tb/tb_hpu_driver.sv

/* run.sh */
#!/bin/sh
# Build and run the driver testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_hpu_driver \
    -f filelist.f \
    -o sim_hpu_driver

out=$(./obj_dir/sim_hpu_driver)
echo "$out"

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
else
    exit 1
fi
